//--- verilog/bp_pkg.sv
package bp_pkg;

  // instructions fetched per cycle
  // slot priority in the top level assumes exactly two
  localparam int num_super = 2;

  // datapath widths
  localparam int pc_width = 64;
  localparam int inst_width = 32;

  // alpha major opcode sits in the top six bits
  localparam int opcode_width = 6;
  localparam int opcode_lsb = 26;

  // conditional branches
  // all share the 0x38 to 0x3f block
  localparam logic [opcode_width-1:0] op_blbc = 6'h38;
  localparam logic [opcode_width-1:0] op_beq = 6'h39;
  localparam logic [opcode_width-1:0] op_blt = 6'h3A;
  localparam logic [opcode_width-1:0] op_ble = 6'h3B;
  localparam logic [opcode_width-1:0] op_blbs = 6'h3C;
  localparam logic [opcode_width-1:0] op_bne = 6'h3D;
  localparam logic [opcode_width-1:0] op_bge = 6'h3E;
  localparam logic [opcode_width-1:0] op_bgt = 6'h3F;

  // unconditional branches
  localparam logic [opcode_width-1:0] op_br = 6'h30;
  localparam logic [opcode_width-1:0] op_bsr = 6'h34;
  // jmp, jsr, ret and jsr_coroutine all decode here
  localparam logic [opcode_width-1:0] op_jsr_grp = 6'h1A;

  // counter encoding
  // 00 strong not-taken, 01 weak not-taken
  // 10 weak taken, 11 strong taken
  localparam logic [1:0] ctr_reset = 2'b01;

  // two 4-byte instructions per fetch group
  localparam logic [pc_width-1:0] fetch_stride = 64'd8;

endpackage

//--- verilog/br_decode.sv
`timescale 1ns/1ps

module br_decode import bp_pkg::*; (
  input  logic [num_super-1:0][inst_width-1:0] ir,
  input  logic [num_super-1:0]                 inst_valid,
  input  logic                                 rollback,
  output logic [num_super-1:0]                 is_cond,
  output logic [num_super-1:0]                 is_uncond
);

  // major opcode per slot
  logic [num_super-1:0][opcode_width-1:0] opcode;

  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      opcode[i] = ir[i][opcode_lsb +: opcode_width];
    end
  end

  // per-slot classification
  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      is_cond[i] = 1'b0;
      is_uncond[i] = 1'b0;
      // squashed or empty slots never count as branches
      if (inst_valid[i] && !rollback) begin
        case (opcode[i])
          op_blbc,
          op_beq,
          op_blt,
          op_ble,
          op_blbs,
          op_bne,
          op_bge,
          op_bgt: begin
            is_cond[i] = 1'b1;
          end
          op_br,
          op_bsr,
          op_jsr_grp: begin
            // always redirect
            is_uncond[i] = 1'b1;
          end
          default: begin
            // not a branch
            is_cond[i] = 1'b0;
            is_uncond[i] = 1'b0;
          end
        endcase
      end
    end
  end

endmodule

//--- verilog/bht.sv
`timescale 1ns/1ps

module bht import bp_pkg::*; #(
  parameter int bh_idx_bits = 6
) (
  input  logic                                  clock,
  input  logic                                  reset,
  // prediction side, one index per fetch slot
  input  logic [num_super-1:0][bh_idx_bits-1:0] rd_idx,
  // training side, one port per resolved branch
  input  logic [num_super-1:0]                  wr_en,
  input  logic [num_super-1:0][bh_idx_bits-1:0] wr_idx,
  input  logic [num_super-1:0]                  wr_taken,
  output logic [num_super-1:0]                  pred_taken
);

  localparam int depth = 2**bh_idx_bits;

  // counter array and its value after this cycle's training
  logic [depth-1:0][1:0] ctr;
  logic [depth-1:0][1:0] ctr_next;

  // one saturating step toward the outcome
  function automatic logic [1:0] sat_step(
    input logic [1:0] ctr_val,
    input logic       taken
  );
    logic [1:0] result;
    result = ctr_val;
    if (taken) begin
      // stop at strong taken
      if (ctr_val != 2'b11) begin
        result = ctr_val + 2'd1;
      end
    end else begin
      // stop at strong not-taken
      if (ctr_val != 2'b00) begin
        result = ctr_val - 2'd1;
      end
    end
    return result;
  endfunction

  // training
  // slot 0 first, slot 1 then steps from slot 0's result
  // so a shared index moves twice in one cycle
  always_comb begin
    ctr_next = ctr;
    for (int i = 0; i < num_super; i++) begin
      if (wr_en[i]) begin
        ctr_next[wr_idx[i]] = sat_step(ctr_next[wr_idx[i]], wr_taken[i]);
      end
    end
  end

  // counter storage
  always_ff @(posedge clock) begin
    if (reset) begin
      // every entry weakly not-taken
      ctr <= {depth{ctr_reset}};
    end else begin
      ctr <= ctr_next;
    end
  end

  // prediction
  // reads the trained array, bypassing same-cycle resolves
  // msb of the counter is the taken decision
  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      pred_taken[i] = ctr_next[rd_idx[i]][1];
    end
  end

endmodule

//--- verilog/btb.sv
`timescale 1ns/1ps

module btb import bp_pkg::*; #(
  parameter int bh_idx_bits = 6
) (
  input  logic                                  clock,
  input  logic                                  reset,
  // lookup, one index per fetch slot
  input  logic [num_super-1:0][bh_idx_bits-1:0] rd_idx,
  // fills from taken resolves only
  input  logic [num_super-1:0]                  wr_en,
  input  logic [num_super-1:0][bh_idx_bits-1:0] wr_idx,
  input  logic [num_super-1:0][pc_width-1:0]    wr_target,
  output logic [num_super-1:0][pc_width-1:0]    pred_target
);

  localparam int depth = 2**bh_idx_bits;

  // untagged target array
  // any pc aliasing onto an index gets that entry
  logic [depth-1:0][pc_width-1:0] tgt;
  logic [depth-1:0][pc_width-1:0] tgt_next;

  // writes in slot order
  // slot 1 lands last and wins a shared index
  always_comb begin
    tgt_next = tgt;
    for (int i = 0; i < num_super; i++) begin
      if (wr_en[i]) begin
        tgt_next[wr_idx[i]] = wr_target[i];
      end
    end
  end

  // target storage
  always_ff @(posedge clock) begin
    if (reset) begin
      // unwritten entries read as zero
      tgt <= '0;
    end else begin
      tgt <= tgt_next;
    end
  end

  // lookup through the written array
  // a fetch in the resolve cycle sees the new target
  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      pred_target[i] = tgt_next[rd_idx[i]];
    end
  end

endmodule

//--- verilog/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor import bp_pkg::*; #(
  parameter int bh_idx_bits = 6
) (
  input  logic                               clock,
  input  logic                               reset,
  // from fetch
  input  logic [num_super-1:0][pc_width-1:0]   pc,
  input  logic [num_super-1:0][inst_width-1:0] ir,
  input  logic [num_super-1:0]                 inst_valid,
  // from execute
  input  logic                                 rollback,
  input  logic [pc_width-1:0]                  rollback_target,
  input  logic [num_super-1:0]                 res_branch,
  input  logic [num_super-1:0]                 res_taken,
  input  logic [num_super-1:0][pc_width-1:0]   res_pc,
  input  logic [num_super-1:0][pc_width-1:0]   res_target,
  // to fetch
  output logic [num_super-1:0]                 take_branch,
  output logic [pc_width-1:0]                  branch_target
);

  // decode results
  logic [num_super-1:0] is_cond;
  logic [num_super-1:0] is_uncond;

  // table indices
  // word-aligned pc bits above the byte offset
  logic [num_super-1:0][bh_idx_bits-1:0] rd_idx;
  logic [num_super-1:0][bh_idx_bits-1:0] wr_idx;

  // table outputs
  logic [num_super-1:0]               pred_taken;
  logic [num_super-1:0][pc_width-1:0] pred_target;

  // btb only learns taken outcomes
  logic [num_super-1:0] btb_wr_en;

  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      rd_idx[i] = pc[i][bh_idx_bits+1:2];
      wr_idx[i] = res_pc[i][bh_idx_bits+1:2];
    end
  end

  assign btb_wr_en = res_branch & res_taken;

  br_decode u_br_decode (
    .ir         (ir),
    .inst_valid (inst_valid),
    .rollback   (rollback),
    .is_cond    (is_cond),
    .is_uncond  (is_uncond)
  );

  bht #(
    .bh_idx_bits (bh_idx_bits)
  ) u_bht (
    .clock      (clock),
    .reset      (reset),
    .rd_idx     (rd_idx),
    .wr_en      (res_branch),
    .wr_idx     (wr_idx),
    .wr_taken   (res_taken),
    .pred_taken (pred_taken)
  );

  btb #(
    .bh_idx_bits (bh_idx_bits)
  ) u_btb (
    .clock       (clock),
    .reset       (reset),
    .rd_idx      (rd_idx),
    .wr_en       (btb_wr_en),
    .wr_idx      (wr_idx),
    .wr_target   (res_target),
    .pred_target (pred_target)
  );

  // per-slot take decision
  // rollback forces both slots to redirect
  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      take_branch[i] = is_uncond[i] | (is_cond[i] & pred_taken[i]) | rollback;
    end
  end

  // redirect target
  // oldest taken slot wins, sequential group last
  always_comb begin
    if (rollback) begin
      branch_target = rollback_target;
    end else if (take_branch[0]) begin
      branch_target = pred_target[0];
    end else if (take_branch[1]) begin
      branch_target = pred_target[1];
    end else begin
      branch_target = pc[0] + fetch_stride;
    end
  end

endmodule

//--- tests/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor import bp_pkg::*; ();

  localparam int clock_period = 100;
  localparam int sample_delay = clock_period - 10;
  localparam int reset_timeout = 20;
  localparam int read_timeout = 1000;

  logic                                 clock;
  logic                                 reset;
  logic [num_super-1:0][pc_width-1:0]   pc;
  logic [num_super-1:0][inst_width-1:0] ir;
  logic [num_super-1:0]                 inst_valid;
  logic                                 rollback;
  logic [pc_width-1:0]                  rollback_target;
  logic [num_super-1:0]                 res_branch;
  logic [num_super-1:0]                 res_taken;
  logic [num_super-1:0][pc_width-1:0]   res_pc;
  logic [num_super-1:0][pc_width-1:0]   res_target;
  logic [num_super-1:0]                 take_branch;
  logic [pc_width-1:0]                  branch_target;

  // one parsed vector
  logic [8*32-1:0]  name_buf;
  logic [8*32-1:0]  cur_test;
  logic [8*256-1:0] line_buf;
  logic [63:0] f_pc0, f_ir0, f_pc1, f_ir1, f_valid, f_rb, f_rb_tgt;
  logic [63:0] f_res_br, f_res_tk, f_res_pc0, f_res_pc1, f_res_tgt0, f_res_tgt1;
  logic [63:0] f_exp_take, f_exp_tgt;

  // bookkeeping
  int  check_count = 0;
  int  error_count = 0;
  int  test_errors = 0;
  int  test_vectors = 0;
  int  tests_ok = 0;
  int  tests_bad = 0;
  logic aborted = 1'b0;

  branch_predictor #(
    .bh_idx_bits (6)
  ) u_branch_predictor (
    .clock           (clock),
    .reset           (reset),
    .pc              (pc),
    .ir              (ir),
    .inst_valid      (inst_valid),
    .rollback        (rollback),
    .rollback_target (rollback_target),
    .res_branch      (res_branch),
    .res_taken       (res_taken),
    .res_pc          (res_pc),
    .res_target      (res_target),
    .take_branch     (take_branch),
    .branch_target   (branch_target)
  );

  // 100 ns clock
  initial clock = 1'b0;
  always #(clock_period / 2) clock = ~clock;

  // reset for two cycles
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
  end

  task automatic check_value(
    input logic [8*32-1:0] test_name,
    input string           what,
    input logic [63:0]     expected,
    input logic [63:0]     actual
  );
    check_count++;
    if (expected !== actual) begin
      error_count++;
      test_errors++;
      $display("ERROR %0s %0s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  // one line per finished test group
  task automatic report_test();
    if (test_vectors > 0) begin
      if (test_errors == 0) begin
        tests_ok++;
        $display("%0s: %0d vectors, ok", cur_test, test_vectors);
      end else begin
        tests_bad++;
        $display("%0s: %0d vectors, %0d mismatches", cur_test, test_vectors, test_errors);
      end
    end
  endtask

  // drive one vector, called right at the rising edge
  task automatic apply_vector();
    logic [inst_width-1:0] junk;
    pc[0] <= f_pc0;
    pc[1] <= f_pc1;
    // invalid slots keep the opcode and carry junk below it
    if (f_valid[0]) begin
      ir[0] <= f_ir0[31:0];
    end else begin
      junk = $urandom;
      ir[0] <= {f_ir0[31:opcode_lsb], junk[opcode_lsb-1:0]};
    end
    if (f_valid[1]) begin
      ir[1] <= f_ir1[31:0];
    end else begin
      junk = $urandom;
      ir[1] <= {f_ir1[31:opcode_lsb], junk[opcode_lsb-1:0]};
    end
    inst_valid <= f_valid[1:0];
    rollback <= f_rb[0];
    rollback_target <= f_rb_tgt;
    res_branch <= f_res_br[1:0];
    res_taken <= f_res_tk[1:0];
    res_pc[0] <= f_res_pc0;
    res_pc[1] <= f_res_pc1;
    res_target[0] <= f_res_tgt0;
    res_target[1] <= f_res_tgt1;
  endtask

  initial begin
    int   seed_val;
    int   fd;
    int   n;
    int   wait_cycles;
    int   read_steps;
    logic done;
    seed_val = $urandom(82);
    pc = '0;
    ir = '0;
    inst_valid = '0;
    rollback = 1'b0;
    rollback_target = '0;
    res_branch = '0;
    res_taken = '0;
    res_pc = '0;
    res_target = '0;
    cur_test = '0;
    done = 1'b0;
    read_steps = 0;
    fd = $fopen("tests/bp_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file tests/bp_patterns.txt");
      aborted = 1'b1;
    end
    // wait for reset release
    if (!aborted) begin
      wait_cycles = 0;
      while (reset !== 1'b0 && wait_cycles < reset_timeout) begin
        @(posedge clock);
        wait_cycles++;
      end
      if (reset !== 1'b0) begin
        $display("reset was still high after %0d cycles", reset_timeout);
        aborted = 1'b1;
      end
    end
    // one vector per cycle
    while (!aborted && !done) begin
      read_steps++;
      line_buf = '0;
      if (read_steps > read_timeout) begin
        $display("pattern file was not done after %0d lines", read_timeout);
        aborted = 1'b1;
      end else if ($fgets(line_buf, fd) == 0) begin
        done = 1'b1;
      end else begin
        name_buf = '0;
        n = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name_buf, f_pc0, f_ir0, f_pc1, f_ir1, f_valid, f_rb, f_rb_tgt,
                    f_res_br, f_res_tk, f_res_pc0, f_res_pc1, f_res_tgt0, f_res_tgt1,
                    f_exp_take, f_exp_tgt);
        if (n == 16) begin
          // new group name closes the previous test
          if (name_buf != cur_test) begin
            report_test();
            cur_test = name_buf;
            test_errors = 0;
            test_vectors = 0;
          end
          @(posedge clock);
          apply_vector();
          // sample late in the cycle
          #(sample_delay);
          test_vectors++;
          check_value(cur_test, "take_branch", f_exp_take, take_branch);
          check_value(cur_test, "branch_target", f_exp_tgt, branch_target);
        end else if (n > 0 && name_buf[7:0] != "#") begin
          $display("pattern file has a line that cannot be parsed: %0s", line_buf);
          aborted = 1'b1;
        end
      end
    end
    report_test();
    if (fd != 0) begin
      $fclose(fd);
    end
    if (!aborted && check_count == 0) begin
      $display("no vectors were found in the pattern file");
      aborted = 1'b1;
    end
    $display("tests ok: %0d, tests failing: %0d, checks: %0d, errors: %0d",
             tests_ok, tests_bad, check_count, error_count);
    if (aborted || error_count != 0) begin
      $display("Test failed");
    end else begin
      $display("Test passed");
    end
    $finish;
  end

endmodule

//--- src.f
verilog/bp_pkg.sv
verilog/br_decode.sv
verilog/bht.sv
verilog/btb.sv
verilog/branch_predictor.sv
tests/tb_branch_predictor.sv

//--- tests/bp_patterns.txt
# columns: test pc0 ir0 pc1 ir1 inst_valid rollback rollback_target res_branch res_taken
# res_pc0 res_pc1 res_target0 res_target1 exp_take_branch exp_branch_target (all hex)

reset_pred 1000 e4000000 1004 f4000000 3 0 0 0 0 0 0 0 0 0 1008
reset_pred 1000 40000000 1004 a4000000 3 0 0 0 0 0 0 0 0 0 1008
reset_pred 1000 c0000000 1004 d0000000 0 0 0 0 0 0 0 0 0 0 1008
reset_pred 1000 c0000000 1004 e4000000 2 0 0 0 0 0 0 0 0 0 1008

uncond 1100 c0000000 1104 40000000 1 0 0 0 0 0 0 0 0 1 0
uncond 1100 40000000 1104 d0000000 3 0 0 0 0 0 0 0 0 2 0
uncond 1200 68000000 1204 c0000000 3 0 0 0 0 0 0 0 0 3 0
uncond 1300 e4000000 1304 68000000 3 0 0 0 0 0 0 0 0 2 0

train 2040 e4000000 2044 40000000 1 0 0 1 1 2040 0 3000 0 1 3000
train 2040 e4000000 2044 40000000 1 0 0 0 0 0 0 0 0 1 3000
train 2040 e4000000 2044 40000000 1 0 0 1 1 2040 0 3000 0 1 3000
train 2040 e4000000 2044 40000000 1 0 0 1 1 2040 0 3000 0 1 3000
train 2040 e4000000 2044 40000000 1 0 0 1 0 2040 0 9999 0 1 3000
train 2040 e4000000 2044 40000000 1 0 0 1 0 2040 0 9999 0 0 2048
train 2040 e4000000 2044 40000000 1 0 0 1 0 2040 0 9999 0 0 2048
train 2040 e4000000 2044 40000000 1 0 0 1 0 2040 0 9999 0 0 2048
train 2040 e4000000 2044 40000000 1 0 0 1 1 2040 0 3000 0 0 2048
train 2040 e4000000 2044 40000000 1 0 0 1 1 2040 0 3000 0 1 3000

btb 20c0 c0000000 2104 c0000000 3 0 0 3 3 20c0 2104 6000 7000 3 6000
btb 20c0 40000000 2104 e4000000 3 0 0 0 0 0 0 0 0 2 7000
btb 20c0 e4000000 2104 f4000000 3 0 0 0 0 0 0 0 0 3 6000
btb 2080 e4000000 2084 40000000 1 0 0 3 3 2080 2080 4000 5000 1 5000
btb 2080 e4000000 2084 40000000 1 0 0 0 0 0 0 0 0 1 5000
btb 2080 e4000000 2084 40000000 1 0 0 3 0 2080 2080 8888 9999 0 2088

rollback 1000 40000000 1004 40000000 3 1 abcd00 0 0 0 0 0 0 3 abcd00
rollback 20c0 c0000000 2104 e4000000 3 1 1234560 0 0 0 0 0 0 3 1234560
rollback 1000 e4000000 1004 e4000000 0 1 5550 0 0 0 0 0 0 3 5550
rollback 1000 e4000000 1004 40000000 1 0 5550 0 0 0 0 0 0 0 1008

btb_keep 2148 e4000000 214c 40000000 1 0 0 1 1 2148 0 a000 0 1 a000
btb_keep 2148 e4000000 214c 40000000 1 0 0 1 1 2148 0 a000 0 1 a000
btb_keep 2148 e4000000 214c 40000000 1 0 0 1 0 2148 0 bbbb 0 1 a000
btb_keep 2148 e4000000 214c 40000000 1 0 0 1 0 2148 0 bbbb 0 0 2150
btb_keep 2148 c0000000 214c 40000000 1 0 0 0 0 0 0 0 0 1 a000
btb_keep 2148 e4000000 214c 40000000 1 0 0 1 1 2148 0 a000 0 1 a000
